//--- design/csync_gen.sv
// Syncs must already be active high; serration timing is valid from the second full line onward
`timescale 1ns/1ps
`default_nettype none

module csync_gen
	import dv_sync_pkg::*;
(
	input  wire  clk_vid,
	input  wire  i_reset,
	input  logic i_hs,
	input  logic i_vs,
	output logic o_csync
);

	logic hs_d;
	logic hs_rise;
	logic hs_fall;

	// Length of the current hsync phase, counted from 1
	sync_count_t h_cnt;

	// Measured hsync pulse width
	sync_count_t hs_len;

	// Point in the low phase where the serration pulse starts
	sync_count_t serr_start;

	logic csync_hs;
	logic csync_vs;

	assign hs_rise = i_hs && !hs_d;
	assign hs_fall = hs_d && !i_hs;

	always_ff @(posedge clk_vid) begin
		if (i_reset) begin
			hs_d       <= 1'b0;
			h_cnt      <= '0;
			hs_len     <= '0;
			serr_start <= '0;
			csync_hs   <= 1'b0;
			csync_vs   <= 1'b0;
		end else begin
			hs_d     <= i_hs;
			csync_vs <= i_vs;

			if (hs_rise || hs_fall)
				h_cnt <= sync_count_t'(1);
			else
				h_cnt <= h_cnt + 1'b1;

			if (hs_fall)
				hs_len <= h_cnt;
			// Low phase length minus one pulse width
			if (hs_rise)
				serr_start <= h_cnt - hs_len;

			// Outside vsync hsync passes straight through
			if (!i_vs)
				csync_hs <= i_hs;
			else if (h_cnt == serr_start)
				csync_hs <= 1'b1;
			else if (hs_rise)
				csync_hs <= 1'b0;
		end
	end

	// Inverted during vsync so the pulse shows as a low notch
	assign o_csync = csync_vs ^ csync_hs;

endmodule

`default_nettype wire

//--- design/dv_delay_line.sv
// Fixed latency of DEPTH clocks with no enable; DEPTH must be at least 1
`timescale 1ns/1ps
`default_nettype none

module dv_delay_line
	import dv_sync_pkg::*;
#(
	parameter int DEPTH = DV_PIPE_DEPTH
) (
	input  wire    clk_vid,
	input  wire    i_reset,
	input  pixel_t i_pixel,
	input  logic   i_de,
	input  logic   i_hs,
	input  logic   i_vs,
	output pixel_t o_pixel,
	output logic   o_de,
	output logic   o_hs,
	output logic   o_vs
);

	// Stage 0 is nearest the input
	pixel_t           pix_pipe [DEPTH];
	logic [DEPTH-1:0] de_pipe;
	logic [DEPTH-1:0] hs_pipe;
	logic [DEPTH-1:0] vs_pipe;

	always_ff @(posedge clk_vid) begin
		if (i_reset) begin
			for (int k = 0; k < DEPTH; k++)
				pix_pipe[k] <= '0;
			de_pipe <= '0;
			hs_pipe <= '0;
			vs_pipe <= '0;
		end else begin
			pix_pipe[0] <= i_pixel;
			de_pipe[0]  <= i_de;
			hs_pipe[0]  <= i_hs;
			vs_pipe[0]  <= i_vs;

			// Shift the rest one stage along
			for (int k = 1; k < DEPTH; k++) begin
				pix_pipe[k] <= pix_pipe[k-1];
				de_pipe[k]  <= de_pipe[k-1];
				hs_pipe[k]  <= hs_pipe[k-1];
				vs_pipe[k]  <= vs_pipe[k-1];
			end
		end
	end

	assign o_pixel = pix_pipe[DEPTH-1];
	assign o_de    = de_pipe[DEPTH-1];
	assign o_hs    = hs_pipe[DEPTH-1];
	assign o_vs    = vs_pipe[DEPTH-1];

endmodule

`default_nettype wire

//--- design/dv_frame_timing.sv
// Input is treated as progressive; frame height is learned on the first vsync, so de is invalid before
`timescale 1ns/1ps
`default_nettype none

module dv_frame_timing
	import dv_sync_pkg::*;
(
	input  wire    clk_vid,
	input  wire    i_reset,
	input  logic   i_ce_pix,
	input  pixel_t i_pixel,
	input  logic   i_hs,
	input  logic   i_vs,
	input  logic   i_csync,
	input  logic   i_csync_en,
	output pixel_t o_pixel,
	output logic   o_de,
	output logic   o_hs,
	output logic   o_vs
);

	////////////////////////////////////////////////////////////
	// Horizontal history and line tracking
	////////////////////////////////////////////////////////////

	// Previous hsync samples, newest in bit 0
	logic [HS_HISTORY_LEN-1:0] hs_hist;

	logic hs_d;
	logic vs_d;
	logic hs_rise;

	// Line counter and captured frame height
	line_count_t vcnt;
	line_count_t vsz;

	// Vertical active window
	logic vde;
	logic de_next;

	assign hs_rise = i_hs && !hs_d;

	// Blank while hsync is high and a few pixels after it
	assign de_next = vde && !i_hs && (hs_hist == '0);

	always_ff @(posedge clk_vid) begin
		if (i_reset) begin
			hs_hist <= '0;
			hs_d    <= 1'b0;
			vs_d    <= 1'b0;
			vcnt    <= '0;
			vsz     <= '0;
			vde     <= 1'b0;
		end else if (i_ce_pix) begin
			hs_hist <= {hs_hist[HS_HISTORY_LEN-2:0], i_hs};
			hs_d    <= i_hs;

			// Vertical state only moves at line start
			if (hs_rise) begin
				vs_d <= i_vs;

				if (vcnt != '1)
					vcnt <= vcnt + 1'b1;
				if (!vs_d && i_vs)
					vsz <= vcnt;
				if (vs_d && !i_vs)
					vcnt <= '0;

				if (vcnt == VDE_START_LINE)
					vde <= 1'b1;
				if (vcnt == vsz - VDE_END_MARGIN)
					vde <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// First output stage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_vid) begin
		if (i_reset) begin
			o_pixel <= '0;
			o_de    <= 1'b0;
			o_hs    <= 1'b0;
			o_vs    <= 1'b0;
		end else begin
			// Pixel data moves every clock
			o_pixel <= i_pixel;

			// Controls hold between pixel enables
			if (i_ce_pix) begin
				o_de <= de_next;
				o_hs <= i_csync_en ? i_csync : i_hs;
				o_vs <= i_vs;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/dv_sync_pkg.sv
// Shared widths and frame constants, for progressive input with at most 8191 lines per frame
`default_nettype none

package dv_sync_pkg;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	// RGB888, red in [23:16], blue in [7:0]
	typedef logic [23:0] pixel_t;

	// Vertical line position inside a frame
	typedef logic [12:0] line_count_t;

	// Sync phase and line lengths in clk_vid cycles
	typedef logic [15:0] sync_count_t;

	////////////////////////////////////////////////////////////
	// Direct video timing constants
	////////////////////////////////////////////////////////////

	// Register stages behind the frame timing stage
	localparam int DV_PIPE_DEPTH = 2;

	// Past hsync samples that must be low before de may rise
	localparam int HS_HISTORY_LEN = 4;

	// First visible line counted from the end of vsync
	localparam line_count_t VDE_START_LINE = 13'd1;

	// Lines cut from the bottom of the measured frame
	localparam line_count_t VDE_END_MARGIN = 13'd3;

endpackage

`default_nettype wire

//--- design/dv_sync_top.sv
// Single clk_vid domain, no back-pressure; syncs settle only after two full periods of each input
`timescale 1ns/1ps
`default_nettype none

module dv_sync_top
	import dv_sync_pkg::*;
(
	input  wire    clk_vid,
	input  wire    i_reset,
	input  pixel_t i_pixel,
	input  logic   i_hs,
	input  logic   i_vs,
	input  logic   i_ce_pix,
	input  logic   i_csync_en,
	output pixel_t o_pixel,
	output logic   o_de,
	output logic   o_hs,
	output logic   o_vs
);

	// Active-high syncs
	logic hs_fix;
	logic vs_fix;
	logic cs;

	// First stage outputs
	pixel_t st1_pixel;
	logic   st1_de;
	logic   st1_hs;
	logic   st1_vs;

	////////////////////////////////////////////////////////////
	// Sync conditioning
	////////////////////////////////////////////////////////////

	sync_polarity_fix u_hs_fix (
		.clk_vid (clk_vid),
		.i_reset (i_reset),
		.i_sync  (i_hs),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix u_vs_fix (
		.clk_vid (clk_vid),
		.i_reset (i_reset),
		.i_sync  (i_vs),
		.o_sync  (vs_fix)
	);

	csync_gen u_csync (
		.clk_vid (clk_vid),
		.i_reset (i_reset),
		.i_hs    (hs_fix),
		.i_vs    (vs_fix),
		.o_csync (cs)
	);

	////////////////////////////////////////////////////////////
	// Output timing
	////////////////////////////////////////////////////////////

	dv_frame_timing u_timing (
		.clk_vid    (clk_vid),
		.i_reset    (i_reset),
		.i_ce_pix   (i_ce_pix),
		.i_pixel    (i_pixel),
		.i_hs       (hs_fix),
		.i_vs       (vs_fix),
		.i_csync    (cs),
		.i_csync_en (i_csync_en),
		.o_pixel    (st1_pixel),
		.o_de       (st1_de),
		.o_hs       (st1_hs),
		.o_vs       (st1_vs)
	);

	dv_delay_line #(
		.DEPTH (DV_PIPE_DEPTH)
	) u_delay (
		.clk_vid (clk_vid),
		.i_reset (i_reset),
		.i_pixel (st1_pixel),
		.i_de    (st1_de),
		.i_hs    (st1_hs),
		.i_vs    (st1_vs),
		.o_pixel (o_pixel),
		.o_de    (o_de),
		.o_hs    (o_hs),
		.o_vs    (o_vs)
	);

endmodule

`default_nettype wire

//--- design/sync_polarity_fix.sv
// Output is active high only once two full sync periods have been seen; phases over 65535 cycles saturate
`timescale 1ns/1ps
`default_nettype none

module sync_polarity_fix
	import dv_sync_pkg::*;
(
	input  wire  clk_vid,
	input  wire  i_reset,
	input  logic i_sync,
	output logic o_sync
);

	// Two-stage sample of the raw sync
	logic sync_d1;
	logic sync_d2;
	logic sync_rise;
	logic sync_fall;

	// Cycles since the last transition
	sync_count_t run_cnt;

	// Last measured phase lengths
	sync_count_t high_len;
	sync_count_t low_len;

	// Set when the sync idles high
	logic pol;

	assign sync_rise = sync_d1 && !sync_d2;
	assign sync_fall = sync_d2 && !sync_d1;

	always_ff @(posedge clk_vid) begin
		if (i_reset) begin
			sync_d1  <= 1'b0;
			sync_d2  <= 1'b0;
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			sync_d1 <= i_sync;
			sync_d2 <= sync_d1;

			// A rising edge ends a low phase and vice versa
			if (sync_rise)
				low_len <= run_cnt;
			if (sync_fall)
				high_len <= run_cnt;

			if (sync_rise || sync_fall)
				run_cnt <= '0;
			else if (run_cnt != '1)
				run_cnt <= run_cnt + 1'b1;

			// The pulse is the shorter phase
			pol <= (high_len > low_len);
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

`default_nettype wire

//--- dv_sync.f
design/dv_sync_pkg.sv
design/sync_polarity_fix.sv
design/csync_gen.sv
design/dv_frame_timing.sv
design/dv_delay_line.sv
design/dv_sync_top.sv
sim/tb_clock_gen.sv
sim/tb_dv_sync.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the fail message
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f dv_sync.f \
	--top-module tb_dv_sync \
	-o sim_dv_sync

./obj_dir/sim_dv_sync > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"

//--- sim/tb_clock_gen.sv
// Free-running clock from time zero; reset is released 2 ns after the last reset edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_vid,
	output logic o_reset
);

	initial begin
		clk_vid = 1'b0;
		forever #(PERIOD_NS / 2) clk_vid = ~clk_vid;
	end

	// Reset held high for a fixed number of rising edges
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_vid);
		#2 o_reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- sim/tb_dv_sync.sv
// Checks assume 40-cycle lines, 20-line frames and syncs that start on a line boundary
`timescale 1ns/1ps
`default_nettype none

module tb_dv_sync
	import dv_sync_pkg::*;
();

	localparam int CLK_NS       = 20;
	localparam int LINE_LEN     = 40;
	localparam int HS_LEN       = 6;
	localparam int FRAME_LINES  = 20;
	localparam int VS_LINES     = 3;
	localparam int IDLE_CYCLES  = 5;
	localparam int TOTAL_FRAMES = 18;
	localparam int WATCHDOG_NS  = (TOTAL_FRAMES * FRAME_LINES * LINE_LEN + 200) * CLK_NS;

	wire    clk_vid;
	wire    i_reset;
	pixel_t i_pixel;
	logic   i_hs;
	logic   i_vs;
	logic   i_ce_pix;
	logic   i_csync_en;
	pixel_t o_pixel;
	logic   o_de;
	logic   o_hs;
	logic   o_vs;

	// Stimulus position and active-high sync levels
	int          cur_line;
	int          cur_col;
	logic        hs_act;
	logic        vs_act;
	logic        active_low;
	logic        ce_alt;
	integer      seed;
	logic [31:0] rnd;

	logic chk_reset;
	logic chk_pix;
	logic chk_sync;
	logic chk_de;
	logic chk_hold;
	int   err_cnt;
	int   test_cnt;
	int   fail_cnt;

	// Reference pipeline whose index 2 lines up with the outputs
	pixel_t     ref_pix [3];
	logic [2:0] ref_de;
	logic [2:0] ref_hs;
	logic [2:0] ref_vs;
	logic [2:0] ce_hist;
	logic       cs_prev;

	tb_clock_gen #(
		.PERIOD_NS    (CLK_NS),
		.RESET_CYCLES (8)
	) u_clk (
		.clk_vid (clk_vid),
		.o_reset (i_reset)
	);

	dv_sync_top i_dut (
		.clk_vid    (clk_vid),
		.i_reset    (i_reset),
		.i_pixel    (i_pixel),
		.i_hs       (i_hs),
		.i_vs       (i_vs),
		.i_ce_pix   (i_ce_pix),
		.i_csync_en (i_csync_en),
		.o_pixel    (o_pixel),
		.o_de       (o_de),
		.o_hs       (o_hs),
		.o_vs       (o_vs)
	);

	////////////////////////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////////////////////////

	// Line index k counts from the end of vsync; the counter lags one line
	function automatic logic de_rule(int line, int col);
		int k;
		int height;
		k = line - VS_LINES;
		height = FRAME_LINES - VS_LINES - 1;
		return (line >= 0) && (k >= int'(VDE_START_LINE) + 1) &&
			(k <= height - int'(VDE_END_MARGIN)) && (col >= HS_LEN + HS_HISTORY_LEN);
	endfunction

	// Serrated during vsync with a low of hs_len cycles up to the hsync rise
	function automatic logic cs_rule(int line, int col);
		if (line < 0)
			return 1'b0;
		if (line < VS_LINES)
			return !(col >= LINE_LEN - HS_LEN);
		return col < HS_LEN;
	endfunction

	always @(posedge clk_vid) begin
		if (i_reset) begin
			ref_pix[0] <= '0;
			ref_pix[1] <= '0;
			ref_pix[2] <= '0;
			ref_de     <= '0;
			ref_hs     <= '0;
			ref_vs     <= '0;
			ce_hist    <= '0;
			cs_prev    <= 1'b0;
		end else begin
			ref_pix[0] <= i_pixel;
			ref_pix[1] <= ref_pix[0];
			ref_pix[2] <= ref_pix[1];
			if (i_ce_pix) begin
				ref_de[0] <= de_rule(cur_line, cur_col);
				ref_hs[0] <= i_csync_en ? cs_prev : hs_act;
				ref_vs[0] <= vs_act;
			end
			ref_de[2:1] <= ref_de[1:0];
			ref_hs[2:1] <= ref_hs[1:0];
			ref_vs[2:1] <= ref_vs[1:0];
			ce_hist     <= {ce_hist[1:0], i_ce_pix};
			cs_prev     <= cs_rule(cur_line, cur_col);
		end
	end

	////////////////////////////////////////////////////////////
	// Checks on the falling edge
	////////////////////////////////////////////////////////////

	task automatic log_mismatch(string msg);
		err_cnt++;
		$display("ERROR @ %0t ns: %s", $time, msg);
	endtask

	a_reset: assert property (@(negedge clk_vid) disable iff (!chk_reset)
		(o_de == 1'b0) && (o_hs == 1'b0) && (o_vs == 1'b0))
		else log_mismatch("control outputs not low after reset");

	a_pixel: assert property (@(negedge clk_vid) disable iff (!chk_pix)
		o_pixel == ref_pix[2])
		else log_mismatch($sformatf("o_pixel %h, expected %h", o_pixel, ref_pix[2]));

	a_hs: assert property (@(negedge clk_vid) disable iff (!chk_sync)
		o_hs == ref_hs[2])
		else log_mismatch($sformatf("o_hs %b, expected %b", o_hs, ref_hs[2]));

	a_vs: assert property (@(negedge clk_vid) disable iff (!chk_sync)
		o_vs == ref_vs[2])
		else log_mismatch($sformatf("o_vs %b, expected %b", o_vs, ref_vs[2]));

	a_de: assert property (@(negedge clk_vid) disable iff (!chk_de)
		o_de == ref_de[2])
		else log_mismatch($sformatf("o_de %b, expected %b", o_de, ref_de[2]));

	// Controls may only move three cycles after a pixel enable
	a_hold: assert property (@(negedge clk_vid) disable iff (!chk_hold)
		ce_hist[2] || ((o_de == $past(o_de)) && (o_hs == $past(o_hs)) &&
		(o_vs == $past(o_vs))))
		else log_mismatch("control output changed without a pixel enable");

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic drive_pixel(int line, int col);
		@(posedge clk_vid);
		#2;
		cur_line = line;
		cur_col  = col;
		hs_act   = (line >= 0) && (col < HS_LEN);
		vs_act   = (line >= 0) && (line < VS_LINES);
		i_hs     = hs_act ^ active_low;
		i_vs     = vs_act ^ active_low;
		rnd      = $random(seed);
		i_pixel  = rnd[23:0];
		i_ce_pix = ce_alt ? ~i_ce_pix : 1'b1;
	endtask

	task automatic close_test(string name, int errs_before);
		test_cnt++;
		if (err_cnt != errs_before)
			fail_cnt++;
		$display("test %0d %s: %s, %0d errors", test_cnt, name,
			(err_cnt == errs_before) ? "ok" : "failed", err_cnt - errs_before);
	endtask

	// Frames before settle are driven but not checked
	task automatic run_test(string name, int frames, int settle, logic low, logic csync,
		logic alt, logic de_on);
		int errs_before;
		errs_before = err_cnt;
		active_low  = low;
		i_csync_en  = csync;
		ce_alt      = alt;
		for (int f = 0; f < frames; f++) begin
			chk_sync = (f >= settle);
			chk_de   = de_on && (f >= settle);
			for (int l = 0; l < FRAME_LINES; l++)
				for (int c = 0; c < LINE_LEN; c++)
					drive_pixel(l, c);
		end
		chk_sync = 1'b0;
		chk_de   = 1'b0;
		close_test(name, errs_before);
	endtask

	initial begin
		seed       = 71816;
		// Syncs and data held active while reset is asserted
		i_pixel    = '1;
		i_hs       = 1'b1;
		i_vs       = 1'b1;
		i_ce_pix   = 1'b1;
		i_csync_en = 1'b0;
		cur_line   = -1;
		cur_col    = 0;
		hs_act     = 1'b0;
		vs_act     = 1'b0;
		active_low = 1'b0;
		ce_alt     = 1'b0;
		chk_reset  = 1'b0;
		chk_pix    = 1'b0;
		chk_sync   = 1'b0;
		chk_de     = 1'b0;
		chk_hold   = 1'b0;
		err_cnt    = 0;
		test_cnt   = 0;
		fail_cnt   = 0;

		repeat (2) @(posedge clk_vid);
		#2;
		chk_reset = 1'b1;
		chk_pix   = 1'b1;
		chk_hold  = 1'b1;
		@(negedge i_reset);
		i_pixel = '0;
		i_hs    = 1'b0;
		i_vs    = 1'b0;
		for (int i = 0; i < IDLE_CYCLES; i++)
			drive_pixel(-1, 0);
		chk_reset = 1'b0;
		close_test("reset", 0);

		run_test("polarity_high", 5, 3, 1'b0, 1'b0, 1'b0, 1'b1);
		run_test("polarity_low", 5, 3, 1'b1, 1'b0, 1'b0, 1'b1);
		run_test("data_enable", 2, 0, 1'b1, 1'b0, 1'b0, 1'b1);
		run_test("csync", 3, 0, 1'b1, 1'b1, 1'b0, 1'b1);
		run_test("pixel_enable", 3, 0, 1'b1, 1'b0, 1'b1, 1'b0);

		repeat (4) @(posedge clk_vid);
		$display("tests run: %0d, failed: %0d, errors: %0d", test_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Whole run length plus a small margin
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
